//--- common/heapPkg.sv
//--------------------
// Shared widths, types and codes of the array heap
// Import into any heap module or testbench that needs them
//--------------------
package heapPkg;

  // ------------------
  // Widths
  // ------------------
  localparam int arrayBits   = 3;                     // Bits in an array number
  localparam int indexBits   = 3;                     // Bits in an element index
  localparam int dataBits    = 16;                    // Bits in one element
  localparam int arrayCount  = 1 << arrayBits;        // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;        // Elements per array

  // ------------------
  // Types
  // ------------------
  typedef logic [arrayBits-1:0] arrayNumT;            // Array number
  typedef logic [indexBits-1:0] indexT;               // Element index
  typedef logic [indexBits:0]   sizeT;                // Size, 0 up to arrayLength
  typedef logic [dataBits-1:0]  dataT;                // Element value
  typedef logic [4:0]           actionT;              // Request action
  typedef logic [2:0]           errorT;               // Response error class

  // ------------------
  // Action codes
  // ------------------
  localparam actionT actClear    = 5'd1;              // Forget every array
  localparam actionT actWrite    = 5'd2;              // Store an element
  localparam actionT actRead     = 5'd3;              // Fetch an element
  localparam actionT actSize     = 5'd4;              // Live size of an array
  localparam actionT actPush     = 5'd14;             // Append at the end
  localparam actionT actPop      = 5'd15;             // Remove from the end
  localparam actionT actAlloc    = 5'd18;             // Hand out an array
  localparam actionT actFree     = 5'd19;             // Give an array back
  localparam actionT actAdd      = 5'd20;             // Add, return new value
  localparam actionT actAddAfter = 5'd21;             // Add, return old value
  localparam actionT actSub      = 5'd22;             // Subtract, return new value
  localparam actionT actSubAfter = 5'd23;             // Subtract, return old value
  localparam actionT actNot      = 5'd27;             // Bitwise invert
  localparam actionT actOr       = 5'd28;             // Bitwise or
  localparam actionT actXor      = 5'd29;             // Bitwise xor
  localparam actionT actAnd      = 5'd30;             // Bitwise and

  // ------------------
  // Error classes
  // ------------------
  localparam errorT errNone        = 3'd0;            // Request done
  localparam errorT errUnallocated = 3'd1;            // Array never issued
  localparam errorT errFreed       = 3'd2;            // Array currently free
  localparam errorT errBounds      = 3'd3;            // Index at or past size
  localparam errorT errFull        = 3'd4;            // Push onto a full array
  localparam errorT errEmpty       = 3'd5;            // Pop from an empty array
  localparam errorT errNoArrays    = 3'd6;            // Nothing left to allocate
  localparam errorT errBadAction   = 3'd7;            // Unknown action code

endpackage

//--- heap/arrayStore.sv
//--------------------
// Element memory and per array sizes of the heap
// One write port each, both read back combinationally
//--------------------
module arrayStore (
  input  logic              clock,
  input  logic              resetN,
  input  heapPkg::arrayNumT selArray,                   // Addressed array
  input  heapPkg::indexT    selIndex,                   // Addressed element
  input  logic              elementWrite,
  input  heapPkg::dataT     elementData,
  input  logic              sizeWrite,
  input  heapPkg::sizeT     newSize,
  output heapPkg::dataT     element,
  output heapPkg::sizeT     size
);
  import heapPkg::*;

  // ------------------
  // Storage
  // ------------------
  dataT elementMem [arrayCount][arrayLength];           // Fixed block per array
  sizeT arraySizes [arrayCount];                        // Live size per array

  // Combinational read of the addressed slot
  assign element = elementMem[selArray][selIndex];
  assign size    = arraySizes[selArray];

  // ------------------
  // Element write port
  // ------------------
  always_ff @(posedge clock) begin
    if (elementWrite) begin
      elementMem[selArray][selIndex] <= elementData;
    end
  end

  // ------------------
  // Size write port
  // ------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrayCount; a++) begin
        arraySizes[a] <= '0;                            // All arrays empty
      end
    end else if (sizeWrite) begin
      arraySizes[selArray] <= newSize;
    end
  end

  // ------------------
  // Assertions
  // ------------------
  // Size stays within one block
  sizeInRange: assert property (@(posedge clock) disable iff (!resetN)
    sizeWrite |-> newSize <= sizeT'(arrayLength));

  // An element write always lands inside the size the array has afterwards
  writeInsideSize: assert property (@(posedge clock) disable iff (!resetN)
    elementWrite |-> {1'b0, selIndex} < (sizeWrite ? newSize : size));

endmodule

//--- heap/heapAllocator.sv
//--------------------
// Array number allocator with live flags and a stack of freed numbers
// Freed numbers are reused last freed first
//--------------------
module heapAllocator (
  input  logic              clock,
  input  logic              resetN,
  input  logic              allocate,                   // Hand out newArray
  input  logic              releaseEn,                  // Take back releaseArray
  input  logic              clear,                      // Forget all arrays
  input  heapPkg::arrayNumT releaseArray,
  input  heapPkg::arrayNumT queryArray,
  output heapPkg::arrayNumT newArray,
  output logic              outOfArrays,
  output logic              arrayIssued,
  output logic              arrayLive
);
  import heapPkg::*;

  logic [arrayCount-1:0] liveFlags;                     // One per array
  logic [arrayBits:0]    issuedCount;                   // Arrays ever handed out
  logic [arrayBits:0]    stackDepth;                    // Entries on free stack
  arrayNumT              freeStack [arrayCount];        // Freed array numbers
  arrayNumT              topSlot;                       // Slot of top entry
  logic                  stackEmpty;

  assign stackEmpty = (stackDepth == '0);
  assign topSlot    = arrayNumT'(stackDepth - 1'b1);

  // ------------------
  // Next number and queries
  // ------------------
  assign newArray    = stackEmpty ? arrayNumT'(issuedCount) : freeStack[topSlot];
  assign outOfArrays = stackEmpty && (issuedCount == arrayCount);
  assign arrayIssued = ({1'b0, queryArray} < issuedCount);
  assign arrayLive   = liveFlags[queryArray];

  // ------------------
  // Flags and counters
  // ------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      liveFlags   <= '0;
      issuedCount <= '0;
      stackDepth  <= '0;
    end else if (clear) begin
      liveFlags   <= '0;                                // Nothing issued, nothing live
      issuedCount <= '0;
      stackDepth  <= '0;
    end else begin
      if (allocate) begin
        liveFlags[newArray] <= 1'b1;
        if (!stackEmpty) begin
          stackDepth <= stackDepth - 1'b1;              // Reuse freed number
        end else begin
          issuedCount <= issuedCount + 1'b1;            // Fresh number
        end
      end
      if (releaseEn) begin
        liveFlags[releaseArray] <= 1'b0;
        stackDepth              <= stackDepth + 1'b1;
      end
    end
  end

  // Stack storage
  always_ff @(posedge clock) begin
    if (releaseEn) begin
      freeStack[arrayNumT'(stackDepth)] <= releaseArray;
    end
  end

  // ------------------
  // Assertions
  // ------------------
  stackNoOverflow: assert property (@(posedge clock) disable iff (!resetN)
    releaseEn |-> stackDepth < arrayCount);
  stackNoUnderflow: assert property (@(posedge clock) disable iff (!resetN)
    allocate |-> !outOfArrays);
  allocReleaseExclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(allocate && releaseEn));

endmodule

//--- heap/heapController.sv
//--------------------
// Request decode, checks and operation FSM of the array heap
// Drives the allocator and store strobes on the execute cycle
//--------------------
module heapController (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cyc,
  input  logic              stb,
  input  heapPkg::actionT   action,
  input  heapPkg::arrayNumT array,
  input  heapPkg::indexT    index,
  input  heapPkg::dataT     writeData,
  output logic              ack,
  output heapPkg::dataT     readData,
  output heapPkg::errorT    error,
  output logic              allocate,
  output logic              releaseEn,
  output logic              clear,
  output heapPkg::arrayNumT releaseArray,
  input  heapPkg::arrayNumT newArray,
  input  logic              outOfArrays,
  input  logic              arrayIssued,
  input  logic              arrayLive,
  output heapPkg::arrayNumT selArray,
  output heapPkg::indexT    selIndex,
  output logic              elementWrite,
  output heapPkg::dataT     elementData,
  output logic              sizeWrite,
  output heapPkg::sizeT     newSize,
  input  heapPkg::dataT     element,
  input  heapPkg::sizeT     size
);
  import heapPkg::*;

  typedef enum logic [1:0] {stIdle, stExecute, stRespond} stateT;

  stateT  state;
  logic   accept;                                       // Request taken this edge
  logic   execute;                                      // Decide and write cycle
  actionT reqAction;                                    // Captured request
  arrayNumT reqArray;
  indexT  reqIndex;
  dataT   reqData;
  errorT  writeableError;                               // Array usable at all
  errorT  readableError;                                // Plus index inside size
  errorT  opError;
  dataT   opResult;                                     // Value for readData
  dataT   opElement;                                    // New element value
  sizeT   opSize;
  logic   opElementWrite;
  logic   opSizeWrite;
  logic   opAllocate;
  logic   opRelease;
  logic   opClear;
  logic   opDone;                                       // Execute with no error

  assign accept  = (state == stIdle) && cyc && stb;
  assign execute = (state == stExecute);
  assign ack     = (state == stRespond);

  // ------------------
  // Request capture
  // ------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      reqAction <= action;
      reqArray  <= array;
      reqIndex  <= index;
      reqData   <= writeData;
    end
  end

  // ------------------
  // Checks
  // ------------------
  assign writeableError = !arrayIssued ? errUnallocated :
                          !arrayLive   ? errFreed       : errNone;
  assign readableError  = (writeableError != errNone) ? writeableError :
                          ({1'b0, reqIndex} >= size)  ? errBounds      : errNone;

  assign selArray = (reqAction == actAlloc) ? newArray : reqArray; // Alloc targets new array

  always_comb begin
    selIndex       = reqIndex;
    opError        = errNone;
    opResult       = '0;
    opElement      = reqData;
    opSize         = size;
    opElementWrite = 1'b0;
    opSizeWrite    = 1'b0;
    opAllocate     = 1'b0;
    opRelease      = 1'b0;
    opClear        = 1'b0;
    case (reqAction)
      actClear: opClear = 1'b1;
      actWrite: begin
        opError        = writeableError;
        opElementWrite = 1'b1;
        opSizeWrite    = ({1'b0, reqIndex} >= size);  // Grows only past the end
        opSize         = sizeT'({1'b0, reqIndex} + 1'b1);
        opResult       = reqData;
      end
      actRead: begin
        opError  = readableError;
        opResult = element;
      end
      actSize: begin
        opError  = writeableError;
        opResult = dataT'(size);
      end
      actPush: begin
        selIndex       = indexT'(size);               // Slot just past the end
        opError        = (writeableError != errNone) ? writeableError :
                         (size == sizeT'(arrayLength)) ? errFull : errNone;
        opElementWrite = 1'b1;
        opSizeWrite    = 1'b1;
        opSize         = size + 1'b1;
      end
      actPop: begin
        selIndex    = indexT'(size - 1'b1);           // Last element
        opError     = (writeableError != errNone) ? writeableError :
                      (size == '0) ? errEmpty : errNone;
        opSizeWrite = 1'b1;
        opSize      = size - 1'b1;
        opResult    = element;
      end
      actAlloc: begin
        opError     = outOfArrays ? errNoArrays : errNone;
        opAllocate  = 1'b1;
        opSizeWrite = 1'b1;                           // Fresh array starts empty
        opSize      = '0;
        opResult    = dataT'(newArray);
      end
      actFree: begin
        opError   = writeableError;
        opRelease = 1'b1;
      end
      actAdd, actAddAfter, actSub, actSubAfter, actAnd, actOr, actXor, actNot: begin
        opError        = readableError;
        opElementWrite = 1'b1;
        case (reqAction)
          actAdd, actAddAfter: opElement = element + reqData; // Wraps to 16 bits
          actSub, actSubAfter: opElement = element - reqData;
          actAnd:              opElement = element & reqData;
          actOr:               opElement = element | reqData;
          actXor:              opElement = element ^ reqData;
          default:             opElement = ~element;
        endcase
        opResult = (reqAction == actAddAfter || reqAction == actSubAfter) ?
                   element : opElement;               // After forms give old value
      end
      default: opError = errBadAction;
    endcase
  end

  // ------------------
  // Strobes, only on a clean execute
  // ------------------
  assign opDone       = execute && (opError == errNone);
  assign elementWrite = opDone && opElementWrite;
  assign elementData  = opElement;
  assign sizeWrite    = opDone && opSizeWrite;
  assign newSize      = opSize;
  assign allocate     = opDone && opAllocate;
  assign releaseEn    = opDone && opRelease;
  assign releaseArray = reqArray;
  assign clear        = opDone && opClear;

  // ------------------
  // FSM and response
  // ------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state    <= stIdle;
      readData <= '0;
      error    <= errNone;
    end else begin
      case (state)
        stIdle: begin
          if (accept) state <= stExecute;
        end
        stExecute: begin
          state    <= stRespond;
          error    <= opError;
          readData <= (opError == errNone) ? opResult : '0; // Zero on any error
        end
        default: state <= stIdle;                     // Respond lasts one cycle
      endcase
    end
  end

  // One ack pulse per request
  ackSingle: assert property (@(posedge clock) disable iff (!resetN) ack |=> !ack);

endmodule

//--- source/arrayHeap.sv
//--------------------
// Top level of the array heap with a Wishbone classic slave port
// One request at a time, ack two cycles after acceptance
//--------------------
module arrayHeap (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cyc,                        // Bus cycle
  input  logic              stb,                        // Request strobe
  input  heapPkg::actionT   action,
  input  heapPkg::arrayNumT array,
  input  heapPkg::indexT    index,
  input  heapPkg::dataT     writeData,
  output logic              ack,
  output heapPkg::dataT     readData,
  output heapPkg::errorT    error
);
  import heapPkg::*;

  // ------------------
  // Internal nets
  // ------------------
  logic     allocate;                                   // Controller to allocator
  logic     releaseEn;
  logic     clear;
  arrayNumT releaseArray;
  arrayNumT newArray;                                   // Allocator to controller
  logic     outOfArrays;
  logic     arrayIssued;
  logic     arrayLive;
  arrayNumT selArray;                                   // Controller to store
  indexT    selIndex;
  logic     elementWrite;
  dataT     elementData;
  logic     sizeWrite;
  sizeT     newSize;
  dataT     element;                                    // Store to controller
  sizeT     size;

  heapController controller0 (
    .clock        (clock),
    .resetN       (resetN),
    .cyc          (cyc),
    .stb          (stb),
    .action       (action),
    .array        (array),
    .index        (index),
    .writeData    (writeData),
    .ack          (ack),
    .readData     (readData),
    .error        (error),
    .allocate     (allocate),
    .releaseEn    (releaseEn),
    .clear        (clear),
    .releaseArray (releaseArray),
    .newArray     (newArray),
    .outOfArrays  (outOfArrays),
    .arrayIssued  (arrayIssued),
    .arrayLive    (arrayLive),
    .selArray     (selArray),
    .selIndex     (selIndex),
    .elementWrite (elementWrite),
    .elementData  (elementData),
    .sizeWrite    (sizeWrite),
    .newSize      (newSize),
    .element      (element),
    .size         (size)
  );

  heapAllocator allocator0 (
    .clock        (clock),
    .resetN       (resetN),
    .allocate     (allocate),
    .releaseEn    (releaseEn),
    .clear        (clear),
    .releaseArray (releaseArray),
    .queryArray   (selArray),                           // Flags of the addressed array
    .newArray     (newArray),
    .outOfArrays  (outOfArrays),
    .arrayIssued  (arrayIssued),
    .arrayLive    (arrayLive)
  );

  arrayStore store0 (
    .clock        (clock),
    .resetN       (resetN),
    .selArray     (selArray),
    .selIndex     (selIndex),
    .elementWrite (elementWrite),
    .elementData  (elementData),
    .sizeWrite    (sizeWrite),
    .newSize      (newSize),
    .element      (element),
    .size         (size)
  );

endmodule

//--- tb/heapChecker.sv
//--------------------
// Reference model and response checker of the array heap
// Watches the bus, checks each ack against the model, counts errors
//--------------------
module heapChecker (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cyc,
  input  logic              stb,
  input  heapPkg::actionT   action,
  input  heapPkg::arrayNumT array,
  input  heapPkg::indexT    index,
  input  heapPkg::dataT     writeData,
  input  logic              ack,
  input  heapPkg::dataT     readData,
  input  heapPkg::errorT    error,
  output int                checkCount,                 // Responses checked
  output int                errorCount                  // Failed checks
);
  import heapPkg::*;

  // ------------------
  // Model state
  // ------------------
  logic     live [arrayCount];                          // Array currently allocated
  int       issued;                                     // Arrays ever handed out
  arrayNumT freed [$];                                  // Freed numbers, top at back
  int       sizes [arrayCount];
  dataT     mem [arrayCount][arrayLength];
  logic     known [arrayCount][arrayLength];            // Element ever written

  logic     busy;                                       // Accepted, ack still due
  logic     fresh;                                      // No request since reset
  int       waitCycles;                                 // Edges since acceptance
  actionT   reqAction;
  arrayNumT reqArray;
  indexT    reqIndex;
  dataT     reqData;
  errorT    expError;
  dataT     expData;
  logic     dataKnown;                                  // Expected value defined

  task automatic resetModel();
    issued = 0;
    freed.delete();
    for (int a = 0; a < arrayCount; a++) begin
      live[a]  = 1'b0;
      sizes[a] = 0;                                     // Elements survive reset
    end
  endtask

  // Apply the captured request, leave the expected response
  task automatic applyModel();
    int    sz;
    int    slot;
    int    idx;
    errorT useError;
    errorT readError;
    dataT  oldVal;
    dataT  newVal;
    sz        = sizes[reqArray];
    idx       = int'(reqIndex);
    useError  = (int'(reqArray) >= issued) ? errUnallocated :
                !live[reqArray] ? errFreed : errNone;
    readError = (useError != errNone) ? useError : (idx >= sz) ? errBounds : errNone;
    expError  = errNone;
    expData   = '0;
    dataKnown = 1'b1;
    case (reqAction)
      actClear: begin
        issued = 0;                                     // Sizes and elements stay
        freed.delete();
        for (int a = 0; a < arrayCount; a++) live[a] = 1'b0;
      end
      actAlloc: begin
        if (freed.size() == 0 && issued == arrayCount) begin
          expError = errNoArrays;
        end else begin
          if (freed.size() != 0) begin
            slot = int'(freed.pop_back());              // Last freed first
          end else begin
            slot = issued;
            issued++;
          end
          live[slot]  = 1'b1;
          sizes[slot] = 0;
          expData     = dataT'(slot);
        end
      end
      actFree: begin
        expError = useError;                            // Double free caught here
        if (expError == errNone) begin
          live[reqArray] = 1'b0;
          freed.push_back(reqArray);
        end
      end
      actWrite: begin
        expError = useError;
        if (expError == errNone) begin
          mem[reqArray][idx]   = reqData;
          known[reqArray][idx] = 1'b1;
          if (idx >= sz) sizes[reqArray] = idx + 1;     // Grow past the end
          expData = reqData;
        end
      end
      actRead: begin
        expError = readError;
        if (expError == errNone) begin
          expData   = mem[reqArray][idx];
          dataKnown = known[reqArray][idx];
        end
      end
      actSize: begin
        expError = useError;
        if (expError == errNone) expData = dataT'(sz);
      end
      actPush: begin
        expError = (useError != errNone) ? useError : (sz == arrayLength) ? errFull : errNone;
        if (expError == errNone) begin
          mem[reqArray][sz]   = reqData;
          known[reqArray][sz] = 1'b1;
          sizes[reqArray]     = sz + 1;
        end
      end
      actPop: begin
        expError = (useError != errNone) ? useError : (sz == 0) ? errEmpty : errNone;
        if (expError == errNone) begin
          expData         = mem[reqArray][sz-1];
          dataKnown       = known[reqArray][sz-1];
          sizes[reqArray] = sz - 1;
        end
      end
      actAdd, actAddAfter, actSub, actSubAfter, actAnd, actOr, actXor, actNot: begin
        expError = readError;
        if (expError == errNone) begin
          oldVal = mem[reqArray][idx];
          case (reqAction)
            actAdd, actAddAfter: newVal = oldVal + reqData;   // Wraps at 16 bits
            actSub, actSubAfter: newVal = oldVal - reqData;
            actAnd:              newVal = oldVal & reqData;
            actOr:               newVal = oldVal | reqData;
            actXor:              newVal = oldVal ^ reqData;
            default:             newVal = ~oldVal;
          endcase
          mem[reqArray][idx] = newVal;
          dataKnown          = known[reqArray][idx];
          expData = (reqAction == actAddAfter || reqAction == actSubAfter) ? oldVal : newVal;
        end
      end
      default: expError = errBadAction;
    endcase
  endtask

  task automatic compareResponse();
    if (error !== expError) begin
      $display("mismatch at %0t: error expected %0d actual %0d (action %0d array %0d)",
               $time, expError, error, reqAction, reqArray);
      errorCount++;
    end
    if (dataKnown && readData !== expData) begin
      $display("mismatch at %0t: readData expected %h actual %h (action %0d array %0d)",
               $time, expData, readData, reqAction, reqArray);
      errorCount++;
    end
  endtask

  // Response outputs hold their reset values until the first request
  task automatic checkResetValues();
    if (error !== errNone) begin
      $display("mismatch at %0t: error after reset expected %0d actual %0d",
               $time, errNone, error);
      errorCount++;
    end
    if (readData !== '0) begin
      $display("mismatch at %0t: readData after reset expected 0000 actual %h",
               $time, readData);
      errorCount++;
    end
  endtask

  initial begin
    checkCount = 0;
    errorCount = 0;
    busy       = 1'b0;
    fresh      = 1'b1;
    waitCycles = 0;
    for (int a = 0; a < arrayCount; a++) begin
      for (int e = 0; e < arrayLength; e++) known[a][e] = 1'b0;
    end
    resetModel();
  end

  // ------------------
  // Bus monitor
  // ------------------
  always @(posedge clock) begin
    if (!resetN) begin
      busy  = 1'b0;
      fresh = 1'b1;
      resetModel();
    end else if (busy) begin
      waitCycles++;
      if (ack) begin
        if (waitCycles != 2) begin
          $display("ack came %0d cycles after acceptance instead of 2, at %0t",
                   waitCycles, $time);
          errorCount++;
        end
        applyModel();
        compareResponse();
        checkCount++;
        busy = 1'b0;
      end else if (waitCycles > 2) begin
        $display("no ack 2 cycles after an accepted request, at %0t", $time);
        errorCount++;
        busy = 1'b0;
      end
    end else begin
      if (ack) begin
        $display("ack high with no request pending or held too long, at %0t", $time);
        errorCount++;
      end
      if (fresh) checkResetValues();
      if (cyc && stb) begin
        reqAction  = action;                            // Heap takes it this edge
        reqArray   = array;
        reqIndex   = index;
        reqData    = writeData;
        busy       = 1'b1;
        fresh      = 1'b0;
        waitCycles = 0;
      end
    end
  end

endmodule

//--- tb/arrayHeapTb.sv
//--------------------
// Testbench top of the array heap
// Directed groups, then seeded random requests over the Wishbone port
//--------------------
module arrayHeapTb;
  import heapPkg::*;

  logic     clock;
  logic     resetN;
  logic     cyc;
  logic     stb;
  actionT   action;
  arrayNumT array;
  indexT    index;
  dataT     writeData;
  logic     ack;
  dataT     readData;
  errorT    error;
  int       checkCount;                                 // From the checker
  int       errorCount;
  int       stallCount;                                 // Waits that ran out
  int       groupStart;                                 // Failures before this group
  int       groupRequests;

  arrayHeap dut0 (
    .clock     (clock),
    .resetN    (resetN),
    .cyc       (cyc),
    .stb       (stb),
    .action    (action),
    .array     (array),
    .index     (index),
    .writeData (writeData),
    .ack       (ack),
    .readData  (readData),
    .error     (error)
  );

  heapChecker checker0 (
    .clock      (clock),
    .resetN     (resetN),
    .cyc        (cyc),
    .stb        (stb),
    .action     (action),
    .array      (array),
    .index      (index),
    .writeData  (writeData),
    .ack        (ack),
    .readData   (readData),
    .error      (error),
    .checkCount (checkCount),
    .errorCount (errorCount)
  );

  always #5 clock = ~clock;                             // Period 10

  function automatic actionT elementOp(input int n);
    case (n % 8)
      0:       return actAdd;
      1:       return actAddAfter;
      2:       return actSub;
      3:       return actSubAfter;
      4:       return actAnd;
      5:       return actOr;
      6:       return actXor;
      default: return actNot;
    endcase
  endfunction

  // ------------------
  // Bus driver
  // ------------------
  task automatic request(input actionT act, input arrayNumT arr, input indexT idx,
                         input dataT data);
    int cycles;
    int logged;
    if (stallCount != 0) return;                        // Heap stuck, stop driving
    logged    = checkCount;
    action    = act;                                    // Called at a falling edge
    array     = arr;
    index     = idx;
    writeData = data;
    cyc       = 1'b1;
    stb       = 1'b1;
    cycles    = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!ack && cycles < 20);
    cyc = 1'b0;                                         // Low before the ack edge ends
    stb = 1'b0;
    groupRequests++;
    if (!ack) begin
      $display("ack never came within 20 cycles, at %0t", $time);
      stallCount++;
      return;
    end
    cycles = 0;
    while (checkCount == logged && cycles < 4) begin
      @(negedge clock);
      cycles++;
    end
    if (checkCount == logged) begin
      $display("checker logged no response for the ack at %0t", $time);
      stallCount++;
    end
  endtask

  // Weighted mix, Alloc and Free often, Clear rarely
  task automatic randomRequest();
    int     pick;
    actionT act;
    pick = $urandom_range(0, 99);
    if (pick < 2)       act = actClear;
    else if (pick < 16) act = actAlloc;
    else if (pick < 26) act = actFree;
    else if (pick < 38) act = actWrite;
    else if (pick < 46) act = actRead;
    else if (pick < 50) act = actSize;
    else if (pick < 60) act = actPush;
    else if (pick < 68) act = actPop;
    else if (pick < 97) act = elementOp(pick - 68);
    else                act = (pick == 99) ? 5'd31 : 5'd9;   // Unused codes
    request(act, arrayNumT'($urandom_range(0, 7)), indexT'($urandom_range(0, 7)),
            dataT'($urandom));
  endtask

  task automatic finishGroup(input string name);
    int failures;
    failures = errorCount + stallCount - groupStart;
    if (failures == 0) $display("group %s: %0d requests, no errors", name, groupRequests);
    else $display("group %s: %0d requests, %0d errors", name, groupRequests, failures);
    groupStart    = errorCount + stallCount;
    groupRequests = 0;
  endtask

  initial begin
    clock         = 1'b0;
    resetN        = 1'b0;
    cyc           = 1'b0;
    stb           = 1'b0;
    action        = '0;
    array         = '0;
    index         = '0;
    writeData     = '0;
    stallCount    = 0;
    groupStart    = 0;
    groupRequests = 0;
    void'($urandom(32'h2570_9e39));
    repeat (5) @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);

    // --------------------
    // Allocation order and reuse
    request(actClear, 0, 0, 0);
    for (int i = 0; i < 9; i++) request(actAlloc, 0, 0, 0);   // 0 to 7, then none
    request(actFree, 3, 0, 0);
    request(actFree, 5, 0, 0);
    request(actFree, 1, 0, 0);
    request(actFree, 5, 0, 0);                          // Already free
    for (int i = 0; i < 3; i++) request(actAlloc, 0, 0, 0);   // Back as 1, 5, 3
    request(actFree, 6, 0, 0);
    request(actSize, 6, 0, 0);
    request(actWrite, 6, 0, 16'h1234);
    request(actClear, 0, 0, 0);
    request(actRead, 2, 0, 0);                          // Never issued since Clear
    request(actFree, 2, 0, 0);
    finishGroup("allocation");

    // Write, Read and Size
    request(actAlloc, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    request(actWrite, 0, 2, 16'hbeef);                  // Size grows to 3
    request(actRead, 0, 2, 0);
    request(actRead, 0, 3, 0);                          // Past the end
    request(actSize, 0, 0, 0);
    request(actWrite, 0, 0, 16'h0101);
    request(actSize, 0, 0, 0);
    request(actWrite, 0, 7, 16'h7777);
    request(actRead, 0, 7, 0);
    request(actSize, 0, 0, 0);
    request(actFree, 0, 0, 0);
    request(actAlloc, 0, 0, 0);                         // Same number, size zero
    request(actSize, 0, 0, 0);
    request(actRead, 0, 0, 0);
    finishGroup("writeRead");

    // Push and Pop
    request(actClear, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    for (int i = 0; i < 9; i++) request(actPush, 0, 0, dataT'($urandom));   // Ninth is full
    for (int i = 0; i < 9; i++) request(actPop, 0, 0, 0);                 // Ninth is empty
    finishGroup("stack");

    // Element arithmetic and bitwise
    request(actClear, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    request(actAlloc, 0, 0, 0);
    for (int i = 0; i < 8; i++) request(actWrite, 0, indexT'(i), dataT'($urandom));
    for (int i = 0; i < 24; i++) begin
      request(elementOp(i), 0, indexT'(i), dataT'($urandom));
      request(actRead, 0, indexT'(i), 0);
    end
    request(actWrite, 0, 0, 16'hfff0);
    request(actAdd, 0, 0, 16'h0020);                    // Wraps over the top
    request(actSubAfter, 0, 0, 16'h0040);               // Wraps below zero
    request(actRead, 0, 0, 0);
    request(actAdd, 1, 0, 16'h0001);                    // Empty array
    finishGroup("elementOps");

    // Random mix
    for (int g = 0; g < 4; g++) begin
      for (int i = 0; i < 475; i++) randomRequest();
      finishGroup($sformatf("random%0d", g));
    end

    $display("requests checked %0d, errors %0d, stalls %0d", checkCount, errorCount,
             stallCount);
    if (errorCount == 0 && stallCount == 0 && checkCount > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
common/heapPkg.sv
heap/arrayStore.sv
heap/heapAllocator.sv
heap/heapController.sv
source/arrayHeap.sv
tb/heapChecker.sv
tb/arrayHeapTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the array heap testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

# Build the simulation binary with assertions enabled
verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayHeapTb -f vlog.f

# Run it and keep the log
./obj_dir/VarrayHeapTb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

# Decide the result from the log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
